//--- all.f
+incdir+tests
design/up_pkg.sv
design/up_ifaces.sv
design/sequencer.sv
design/register_bank.sv
design/result_unit.sv
design/program_memory.sv
design/up_core.sv
tests/up_core_tb.sv

//--- design/program_memory.sv
`timescale 1ns/1ps

module program_memory import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  logic  load,
   input  word_t mem_in,
   output word_t mem_out,
   output word_t map_01,
   ctrl_if.sink  ctrl,
   mem_if.memory mem
);

   word_t mem_q [MEM_DEPTH];
   word_t addr_q;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst)
         addr_q <= '0;
      else if (load)
         addr_q <= '0;
      else if (ctrl.ale)
         addr_q <= mem.result;
   end

   // While loading, the whole array is one shift register fed at byte 0
   always_ff @(posedge clk) begin
      if (load) begin
         mem_q[0] <= mem_in;
         for (int i = 1; i < MEM_DEPTH; i++)
            mem_q[i] <= mem_q[i-1];
      end else if (ctrl.mem_we) begin
         mem_q[addr_q] <= mem.result;
      end
   end

   assign mem.rdata = mem_q[addr_q];
   assign mem_out   = mem_q[OUT_ADDR];
   assign map_01    = mem_q[MAP_ADDR];

endmodule

//--- design/register_bank.sv
`timescale 1ns/1ps

module register_bank import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  logic  load,
   input  word_t data_in,
   input  word_t result,
   ctrl_if.sink  ctrl,
   reg_if.source regs
);

   word_t r_q [4];
   word_t sp_q;
   word_t pc_q;
   word_t wr_data;

   // Loads from memory bypass the result unit
   assign wr_data = ctrl.reg_from_mem ? data_in : result;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         for (int i = 0; i < 4; i++)
            r_q[i] <= '0;
         sp_q <= SP_RESET;
         pc_q <= PC_RESET;
      end else if (load) begin
         for (int i = 0; i < 4; i++)
            r_q[i] <= '0;
         sp_q <= SP_RESET;
         pc_q <= PC_RESET;
      end else begin
         if (ctrl.reg_we)
            r_q[ctrl.rd_idx] <= wr_data;
         if (ctrl.sp_we)
            sp_q <= result;
         if (ctrl.pc_we)
            pc_q <= result;
      end
   end

   assign regs.r0 = r_q[0];
   assign regs.r1 = r_q[1];
   assign regs.r2 = r_q[2];
   assign regs.r3 = r_q[3];
   assign regs.sp = sp_q;
   assign regs.pc = pc_q;

   // Branch condition for BE
   assign regs.z  = (r_q[1] == r_q[2]);

endmodule

//--- design/result_unit.sv
`timescale 1ns/1ps

module result_unit import up_pkg::*; (
   ctrl_if.sink      ctrl,
   reg_if.sink       regs,
   mem_if.result_drv mem
);

   word_t fetch_addr;

   // Byte that holds the current instruction nibble
   assign fetch_addr = {1'b0, regs.pc[7:1]};

   // All arithmetic wraps at 8 bits
   always_comb begin
      case (ctrl.result_sel)
         RES_ZERO:       mem.result = 8'd0;
         RES_ONE:        mem.result = 8'd1;
         RES_TWO:        mem.result = 8'd2;
         RES_THREE:      mem.result = 8'd3;
         RES_FETCH_ADDR: mem.result = fetch_addr;
         RES_PC_INC:     mem.result = regs.pc + 8'd1;
         RES_PC_DEC:     mem.result = regs.pc - 8'd1;
         RES_SUM:        mem.result = regs.r1 + regs.r2;
         RES_DIFF:       mem.result = regs.r1 - regs.r2;
         RES_PROD:       mem.result = regs.r1 * regs.r2;
         RES_NAND:       mem.result = ~(regs.r1 & regs.r2);
         RES_XOR01:      mem.result = regs.r0 ^ regs.r1;
         RES_XOR12:      mem.result = regs.r1 ^ regs.r2;
         RES_XOR23:      mem.result = regs.r2 ^ regs.r3;
         RES_R3:         mem.result = regs.r3;
         RES_R2:         mem.result = regs.r2;
         RES_SP_INC:     mem.result = regs.sp + 8'd1;
         RES_SP_DEC:     mem.result = regs.sp - 8'd1;
         RES_SP:         mem.result = regs.sp;
         RES_MEM:        mem.result = mem.rdata;
         default:        mem.result = 8'd0;
      endcase
   end

endmodule

//--- design/sequencer.sv
`timescale 1ns/1ps

module sequencer import up_pkg::*; (
   input  logic   clk,
   input  logic   nRst,
   input  logic   load,
   input  word_t  data_in,
   ctrl_if.source ctrl,
   reg_if.sink    regs
);

   state_t      state_q;
   state_t      state_d;
   opcode_t     ir_q;
   nibble_t     ir_nib;
   logic        is_swap;
   reg_idx_t    swap_lo;
   result_sel_t swap_sel;

   // Low nibble holds the even instruction
   assign ir_nib = regs.pc[0] ? data_in[7:4] : data_in[3:0];

   // Swaps are three XOR writes: lower, upper, lower register of the pair
   always_comb begin
      is_swap  = 1'b1;
      swap_lo  = 2'd0;
      swap_sel = RES_XOR01;
      case (ir_q)
         IR_SW01: swap_lo = 2'd0;
         IR_SW12: begin
            swap_lo  = 2'd1;
            swap_sel = RES_XOR12;
         end
         IR_SW23: begin
            swap_lo  = 2'd2;
            swap_sel = RES_XOR23;
         end
         default: is_swap = 1'b0;
      endcase
   end

   // ====================
   // State sequence
   // ====================

   always_comb begin
      state_d = FETCH;
      case (state_q)
         LOAD_REGS_0: state_d = LOAD_REGS_1;
         LOAD_REGS_1: state_d = LOAD_REGS_2;
         LOAD_REGS_2: state_d = LOAD_REGS_3;
         LOAD_REGS_3: state_d = LOAD_REGS_4;
         FETCH:       state_d = DECODE;
         DECODE:      state_d = EXECUTE_1;
         EXECUTE_1: begin
            if (is_swap || ir_q inside {IR_PUSH, IR_PUSHC, IR_POP, IR_POPC,
                                        IR_LDW, IR_STW, IR_REF})
               state_d = EXECUTE_2;
         end
         EXECUTE_2: begin
            if (is_swap || ir_q inside {IR_PUSH, IR_PUSHC})
               state_d = EXECUTE_3;
         end
         default:     state_d = FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state_q <= LOAD_REGS_0;
         ir_q    <= IR_ADD;
      end else if (load) begin
         state_q <= LOAD_REGS_0;
         ir_q    <= IR_ADD;
      end else begin
         state_q <= state_d;
         if (state_q == DECODE)
            ir_q <= opcode_t'(ir_nib);
      end
   end

   // ====================
   // Control decode
   // ====================

   always_comb begin
      ctrl.result_sel   = RES_ZERO;
      ctrl.rd_idx       = 2'd0;
      ctrl.reg_we       = 1'b0;
      ctrl.reg_from_mem = 1'b0;
      ctrl.sp_we        = 1'b0;
      ctrl.pc_we        = 1'b0;
      ctrl.mem_we       = 1'b0;
      ctrl.ale          = 1'b0;
      case (state_q)
         // Nothing here, the address is already zero after reset or load
         LOAD_REGS_0: ;
         LOAD_REGS_1, LOAD_REGS_2, LOAD_REGS_3, LOAD_REGS_4: begin
            ctrl.ale          = 1'b1;
            ctrl.reg_we       = 1'b1;
            ctrl.reg_from_mem = 1'b1;
            case (state_q)
               LOAD_REGS_1: ctrl.result_sel = RES_ONE;
               LOAD_REGS_2: ctrl.result_sel = RES_TWO;
               LOAD_REGS_3: ctrl.result_sel = RES_THREE;
               default:     ctrl.result_sel = RES_FETCH_ADDR;
            endcase
            case (state_q)
               LOAD_REGS_1: ctrl.rd_idx = 2'd0;
               LOAD_REGS_2: ctrl.rd_idx = 2'd1;
               LOAD_REGS_3: ctrl.rd_idx = 2'd2;
               default:     ctrl.rd_idx = 2'd3;
            endcase
         end
         FETCH: begin
            ctrl.result_sel = RES_FETCH_ADDR;
            ctrl.ale        = 1'b1;
         end
         DECODE: begin
            ctrl.result_sel = RES_PC_INC;
            ctrl.pc_we      = 1'b1;
         end
         EXECUTE_1: begin
            case (ir_q)
               IR_ADD, IR_SUB, IR_MUL, IR_NAND: begin
                  ctrl.reg_we = 1'b1;
                  case (ir_q)
                     IR_ADD:  ctrl.result_sel = RES_SUM;
                     IR_SUB:  ctrl.result_sel = RES_DIFF;
                     IR_MUL:  ctrl.result_sel = RES_PROD;
                     default: ctrl.result_sel = RES_NAND;
                  endcase
               end
               IR_SW01, IR_SW12, IR_SW23: begin
                  ctrl.result_sel = swap_sel;
                  ctrl.rd_idx     = swap_lo;
                  ctrl.reg_we     = 1'b1;
               end
               IR_BE: begin
                  ctrl.result_sel = RES_R3;
                  ctrl.pc_we      = regs.z;
               end
               IR_POP, IR_POPC: begin
                  ctrl.result_sel = RES_SP_INC;
                  ctrl.sp_we      = 1'b1;
                  ctrl.ale        = 1'b1;
               end
               IR_PUSH, IR_PUSHC: begin
                  ctrl.result_sel = RES_SP;
                  ctrl.ale        = 1'b1;
               end
               IR_LDW, IR_STW: begin
                  ctrl.result_sel = RES_R3;
                  ctrl.ale        = 1'b1;
               end
               IR_REF: ctrl.ale = 1'b1;
               // IR_INT does nothing
               default: ;
            endcase
         end
         EXECUTE_2: begin
            case (ir_q)
               IR_SW01, IR_SW12, IR_SW23: begin
                  ctrl.result_sel = swap_sel;
                  ctrl.rd_idx     = swap_lo + 2'd1;
                  ctrl.reg_we     = 1'b1;
               end
               IR_POPC: begin
                  ctrl.result_sel = RES_MEM;
                  ctrl.pc_we      = 1'b1;
               end
               IR_PUSH, IR_PUSHC: begin
                  ctrl.result_sel = RES_SP_DEC;
                  ctrl.sp_we      = 1'b1;
               end
               IR_POP, IR_LDW, IR_REF: begin
                  ctrl.rd_idx       = (ir_q == IR_REF) ? 2'd0 : 2'd2;
                  ctrl.reg_we       = 1'b1;
                  ctrl.reg_from_mem = 1'b1;
               end
               IR_STW: begin
                  ctrl.result_sel = RES_R2;
                  ctrl.mem_we     = 1'b1;
               end
               default: ;
            endcase
         end
         EXECUTE_3: begin
            case (ir_q)
               IR_SW01, IR_SW12, IR_SW23: begin
                  ctrl.result_sel = swap_sel;
                  ctrl.rd_idx     = swap_lo;
                  ctrl.reg_we     = 1'b1;
               end
               IR_PUSH: begin
                  ctrl.result_sel = RES_R2;
                  ctrl.mem_we     = 1'b1;
               end
               IR_PUSHC: begin
                  ctrl.result_sel = RES_PC_DEC;
                  ctrl.mem_we     = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

//--- design/up_core.sv
`timescale 1ns/1ps

module up_core import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  logic  load,
   input  word_t mem_in,
   output word_t mem_out,
   output word_t map_01
);

   ctrl_if ctrl_bus ();
   reg_if  reg_bus ();
   mem_if  mem_bus ();

   sequencer u_sequencer (
      .clk     (clk),
      .nRst    (nRst),
      .load    (load),
      .data_in (mem_bus.rdata),
      .ctrl    (ctrl_bus.source),
      .regs    (reg_bus.sink)
   );

   register_bank u_register_bank (
      .clk     (clk),
      .nRst    (nRst),
      .load    (load),
      .data_in (mem_bus.rdata),
      .result  (mem_bus.result),
      .ctrl    (ctrl_bus.sink),
      .regs    (reg_bus.source)
   );

   // Single write-back word for registers, address and memory
   result_unit u_result_unit (
      .ctrl (ctrl_bus.sink),
      .regs (reg_bus.sink),
      .mem  (mem_bus.result_drv)
   );

   program_memory u_program_memory (
      .clk     (clk),
      .nRst    (nRst),
      .load    (load),
      .mem_in  (mem_in),
      .mem_out (mem_out),
      .map_01  (map_01),
      .ctrl    (ctrl_bus.sink),
      .mem     (mem_bus.memory)
   );

endmodule

//--- design/up_ifaces.sv
`timescale 1ns/1ps

// Control strobes and selections from the sequencer
interface ctrl_if import up_pkg::*; ();

   result_sel_t result_sel;
   reg_idx_t    rd_idx;
   logic        reg_we;
   logic        reg_from_mem;
   logic        sp_we;
   logic        pc_we;
   logic        mem_we;
   logic        ale;

   modport source (
      output result_sel, rd_idx, reg_we, reg_from_mem, sp_we, pc_we, mem_we, ale
   );

   modport sink (
      input result_sel, rd_idx, reg_we, reg_from_mem, sp_we, pc_we, mem_we, ale
   );

endinterface

// Architectural register values from the register bank
interface reg_if import up_pkg::*; ();

   word_t r0;
   word_t r1;
   word_t r2;
   word_t r3;
   word_t sp;
   word_t pc;
   logic  z;

   modport source (output r0, r1, r2, r3, sp, pc, z);

   modport sink (input r0, r1, r2, r3, sp, pc, z);

endinterface

// Write-back word and the byte read at the latched address
interface mem_if import up_pkg::*; ();

   word_t result;
   word_t rdata;

   modport result_drv (output result, input rdata);

   modport memory (input result, output rdata);

endinterface

//--- design/up_pkg.sv
package up_pkg;

   // Data byte, byte address and nibble program counter
   typedef logic [7:0] word_t;

   // One instruction, two per memory byte
   typedef logic [3:0] nibble_t;

   // Selects r0 to r3
   typedef logic [1:0] reg_idx_t;

   localparam int    MEM_DEPTH = 256;
   localparam word_t PC_RESET  = 8'd8;
   localparam word_t SP_RESET  = 8'd255;
   localparam word_t MAP_ADDR  = 8'd126;
   localparam word_t OUT_ADDR  = 8'd255;

   typedef enum logic [3:0] {
      IR_ADD   = 4'h0,
      IR_SUB   = 4'h1,
      IR_MUL   = 4'h2,
      IR_NAND  = 4'h3,
      IR_SW01  = 4'h4,
      IR_SW12  = 4'h5,
      IR_SW23  = 4'h6,
      IR_BE    = 4'h7,
      IR_POPC  = 4'h8,
      IR_PUSHC = 4'h9,
      IR_POP   = 4'hA,
      IR_PUSH  = 4'hB,
      IR_LDW   = 4'hC,
      IR_STW   = 4'hD,
      IR_REF   = 4'hE,
      IR_INT   = 4'hF
   } opcode_t;

   typedef enum logic [3:0] {
      LOAD_REGS_0,
      LOAD_REGS_1,
      LOAD_REGS_2,
      LOAD_REGS_3,
      LOAD_REGS_4,
      FETCH,
      DECODE,
      EXECUTE_1,
      EXECUTE_2,
      EXECUTE_3
   } state_t;

   typedef enum logic [4:0] {
      RES_ZERO,
      RES_ONE,
      RES_TWO,
      RES_THREE,
      RES_FETCH_ADDR,
      RES_PC_INC,
      RES_PC_DEC,
      RES_SUM,
      RES_DIFF,
      RES_PROD,
      RES_NAND,
      RES_XOR01,
      RES_XOR12,
      RES_XOR23,
      RES_R3,
      RES_R2,
      RES_SP_INC,
      RES_SP_DEC,
      RES_SP,
      RES_MEM
   } result_sel_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   -f all.f --top-module up_core_tb -o up_core_sim

sim_out="$(./obj_dir/up_core_sim)"
echo "$sim_out"

if grep -qx "all tests passed" <<< "$sim_out"; then
   exit 0
fi
exit 1

//--- tests/up_tests.svh
`ifndef UP_TESTS_SVH
`define UP_TESTS_SVH

// ====================
// Directed tests
// ====================

function automatic word_t arith_expect(input opcode_t op, input word_t a, input word_t b);
   case (op)
      IR_ADD:  return a + b;
      IR_SUB:  return a - b;
      IR_MUL:  return a * b;
      default: return ~(a & b);
   endcase
endfunction

// Taps are read while load is still high
task automatic test_shift_load();
   // Fully random so that a misplaced shift shows on both taps
   for (int i = 0; i < MEM_DEPTH; i++)
      img[i] = rand_byte();
   shift_image();
   check_word(mem_out, img[MEM_DEPTH - 1], "mem_out after shift load");
   check_word(map_01, img[MEM_DEPTH - 130], "map_01 after shift load");
endtask

// Result lands in r0, the swaps move it to r2 and STW writes byte 255
task automatic arith_case(input opcode_t op);
   word_t a;
   word_t b;
   word_t exp;
   int    n;
   a   = rand_byte();
   b   = rand_byte();
   exp = arith_expect(op, a, b);
   fill_image();
   set_regs(rand_byte(), a, b, OUT_ADDR);
   img[OUT_ADDR] = ~exp;
   prog = {op, IR_SW01, IR_SW12, IR_STW};
   n = place_program();
   shift_image();
   run_program(n);
   check_word(mem_out, exp, $sformatf("%s result on mem_out", op.name()));
endtask

task automatic test_arith_swaps();
   opcode_t ops [4] = '{IR_ADD, IR_SUB, IR_MUL, IR_NAND};
   foreach (ops[k])
      arith_case(ops[k]);
endtask

task automatic test_map_store();
   word_t v;
   int    n;
   // Odd values never match the REF filler already at byte 126
   v = rand_byte() | 8'h01;
   fill_image();
   set_regs(rand_byte(), rand_byte(), v, MAP_ADDR);
   prog = {IR_STW};
   n = place_program();
   shift_image();
   run_program(n - 1);
   check_word(map_01, 8'hEE, "map_01 before the STW write edge");
   step_cycles(1, "STW write edge");
   check_word(map_01, v, "map_01 after STW");
endtask

// r3 is both the branch target nibble and the store address, so both
// stores hit byte 126. The fall-through path then stores r1 + r2 there.
task automatic branch_case(input logic taken);
   word_t a;
   word_t b;
   int    first;
   int    n;
   b = rand_byte() | 8'h01;
   a = rand_byte() | 8'h01;
   if (taken)
      a = b;
   else if (a == b)
      a = a + 8'h02;
   fill_image();
   set_regs(rand_byte(), a, b, MAP_ADDR);
   prog = {IR_BE, IR_STW, IR_ADD, IR_SW01, IR_SW12, IR_STW};
   n = place_program();
   put_nibble(MAP_ADDR, IR_STW);
   first = START_CYCLES + instr_cycles(IR_BE) + instr_cycles(IR_STW);
   shift_image();
   run_program(first);
   check_word(map_01, b, $sformatf("branch taken=%0b, first store", taken));
   step_cycles(n - first, "branch tail");
   check_word(map_01, taken ? b : a + b, $sformatf("branch taken=%0b, path", taken));
endtask

task automatic test_branch();
   branch_case(1'b1);
   branch_case(1'b0);
endtask

task automatic test_stack();
   word_t v;
   int    n;
   // PUSH with the reset stack pointer
   v = rand_byte();
   fill_image();
   set_regs(rand_byte(), rand_byte(), v, rand_byte());
   img[OUT_ADDR] = ~v;
   prog = {IR_PUSH};
   n = place_program();
   shift_image();
   run_program(n);
   check_word(mem_out, v, "PUSH of r2 to byte 255");

   // POP wraps sp to 0 and picks up the r0 byte
   // r2 starts as the complement so only the POP load can make it v
   v = rand_byte();
   fill_image();
   set_regs(v, rand_byte(), ~v, OUT_ADDR);
   img[OUT_ADDR] = ~v;
   prog = {IR_POP, IR_STW};
   n = place_program();
   shift_image();
   run_program(n);
   check_word(mem_out, v, "POP from byte 0 then STW");

   // PUSHC in the second nibble slot
   fill_image();
   set_regs(rand_byte(), rand_byte(), rand_byte(), rand_byte());
   img[OUT_ADDR] = ~(PC_RESET + 8'd1);
   prog = {IR_NAND, IR_PUSHC};
   n = place_program();
   shift_image();
   run_program(n);
   check_word(mem_out, PC_RESET + 8'd1, "PUSHC stores its nibble address");
endtask

task automatic test_ref_ldw();
   word_t v;
   word_t a;
   word_t b;
   word_t addr;
   int    n;
   // ADD clobbers r0 so that REF has something to restore
   v = rand_byte();
   a = rand_byte();
   b = rand_byte();
   if (word_t'(a + b) == v)
      b = b + 8'd1;
   fill_image();
   set_regs(v, a, b, OUT_ADDR);
   img[OUT_ADDR] = ~v;
   prog = {IR_ADD, IR_REF, IR_SW01, IR_SW12, IR_STW};
   n = place_program();
   shift_image();
   run_program(n);
   check_word(mem_out, v, "REF reload of r0 moved to byte 255");

   // LDW from the random data half, PUSH exposes r2 on byte 255
   v    = rand_byte();
   addr = 8'd200;
   fill_image();
   img[addr] = v;
   set_regs(rand_byte(), rand_byte(), ~v, addr);
   img[OUT_ADDR] = ~v;
   prog = {IR_LDW, IR_PUSH};
   n = place_program();
   shift_image();
   run_program(n);
   check_word(mem_out, v, "LDW of byte 200 into r2");
endtask

`endif

//--- tests/up_core_tb.sv
`timescale 1ns/1ps

module up_core_tb import up_pkg::*; ();

   // Longest wait any single step may take
   localparam int STEP_LIMIT   = 2000;
   // LOAD_REGS_0 to LOAD_REGS_4 before the first fetch
   localparam int START_CYCLES = 5;

   logic   clk;
   logic   nRst;
   logic   load;
   word_t  mem_in;
   word_t  mem_out;
   word_t  map_01;

   integer  seed;
   int      errors;
   int      checks;
   bit      finished;
   word_t   img [MEM_DEPTH];
   opcode_t prog [$];

   up_core dut0 (
      .clk     (clk),
      .nRst    (nRst),
      .load    (load),
      .mem_in  (mem_in),
      .mem_out (mem_out),
      .map_01  (map_01)
   );

   always #20 clk = ~clk;

   // ====================
   // Checks and reporting
   // ====================

   task automatic check_word(input word_t got, input word_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: %s, got %02h, expected %02h", $time, msg, got, exp);
      end
   endtask

   task automatic report_and_finish();
      if (!finished) begin
         finished = 1'b1;
         $display("checks: %0d, errors: %0d", checks, errors);
         if (errors == 0)
            $display("all tests passed");
         else
            $display("tests failed");
         $finish;
      end
   endtask

   // Every wait in the testbench goes through here
   task automatic step_cycles(input int n, input string what);
      int i;
      i = 0;
      while (i < n) begin
         if (i >= STEP_LIMIT) begin
            errors++;
            $display("Timeout: %s did not end within %0d cycles", what, STEP_LIMIT);
            report_and_finish();
         end
         @(negedge clk);
         i++;
      end
   endtask

   // ====================
   // Image building
   // ====================

   function automatic word_t rand_byte();
      return word_t'($random(seed));
   endfunction

   // Random bytes everywhere, REF pairs over the whole executable half
   function automatic void fill_image();
      for (int i = 0; i < MEM_DEPTH; i++)
         img[i] = rand_byte();
      for (int i = 4; i < MEM_DEPTH / 2; i++)
         img[i] = 8'hEE;
   endfunction

   function automatic void set_regs(input word_t v0, input word_t v1,
                                    input word_t v2, input word_t v3);
      img[0] = v0;
      img[1] = v1;
      img[2] = v2;
      img[3] = v3;
   endfunction

   // Even nibble addresses sit in the low half of a byte
   function automatic void put_nibble(input word_t nib, input opcode_t op);
      word_t b;
      b = nib >> 1;
      if (nib[0])
         img[b][7:4] = op;
      else
         img[b][3:0] = op;
   endfunction

   function automatic int instr_cycles(input opcode_t op);
      case (op)
         IR_LDW, IR_STW, IR_POP, IR_POPC, IR_REF:       return 4;
         IR_SW01, IR_SW12, IR_SW23, IR_PUSH, IR_PUSHC: return 5;
         default:                                      return 3;
      endcase
   endfunction

   // Lays prog out from the first nibble and returns its straight-line run time
   function automatic int place_program();
      int cycles;
      cycles = START_CYCLES;
      foreach (prog[k]) begin
         put_nibble(PC_RESET + word_t'(k), prog[k]);
         cycles += instr_cycles(prog[k]);
      end
      return cycles;
   endfunction

   // ====================
   // DUT driving
   // ====================

   // Last byte goes in first so that byte k ends up holding img[k]
   task automatic shift_image();
      for (int i = MEM_DEPTH - 1; i >= 0; i--) begin
         load   = 1'b1;
         mem_in = img[i];
         @(negedge clk);
      end
   endtask

   task automatic run_program(input int cycles);
      load = 1'b0;
      step_cycles(cycles, "program run");
   endtask

   `include "up_tests.svh"

   initial begin
      seed     = 32'h50c25322;
      errors   = 0;
      checks   = 0;
      finished = 1'b0;
      clk      = 1'b0;
      nRst     = 1'b0;
      load     = 1'b0;
      mem_in   = '0;
      step_cycles(4, "reset");
      nRst = 1'b1;

      test_shift_load();
      test_arith_swaps();
      test_map_store();
      test_branch();
      test_stack();
      test_ref_ldw();

      report_and_finish();
   end

endmodule
